/* Makefile */
VERILATOR ?= verilator
TOP       ?= tbCustomInstr
FLIST     ?= vlog.f
OBJ_DIR   ?= obj_dir
FLAGS     ?= --binary --timing --timescale 1ns/1ps

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

# The pipeline status is that of grep, so a missing pass line fails the target
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qxF '** PASS **'

clean:
	rm -rf $(OBJ_DIR)

/* testbench/ciChecker.sv */
`include "customInstr_consts.svh"

module ciChecker
  import customInstrPkg::*;
#(
  parameter int nameBits = 160
) (
  input  logic                s_systemClock,
  input  logic                s_pllLocked,
  input  logic                ciReset,
  input  logic                peripheralResetN,
  input  logic                ciDone,
  input  ciWordT              ciResult,
  input  logic                expArm,
  input  ciWordT              expResult,
  input  int                  expLatency,
  input  logic [nameBits-1:0] testName,
  output int                  checkCount,
  output int                  valueErrors,
  output int                  protocolErrors
);

  timeunit 1ns;
  timeprecision 1ps;

  int                  numChecks = 0;
  int                  numValueErrors = 0;
  int                  numProtocolErrors = 0;
  int                  waitCycles = 0;
  int                  lockCycles = 0;
  logic                lockTracking = 1'b0;
  logic                pending = 1'b0;
  ciWordT              expResultReg = '0;
  int                  expLatencyReg = 0;
  logic [nameBits-1:0] nameReg = '0;

  assign checkCount     = numChecks;
  assign valueErrors    = numValueErrors;
  assign protocolErrors = numProtocolErrors;

  always @(posedge s_systemClock) begin
    // Reset sequencing after PLL lock
    if (!s_pllLocked) begin
      lockCycles   = 0;
      lockTracking = 1'b1;
    end else if (lockTracking) begin
      if (peripheralResetN) begin
        lockTracking = 1'b0;
        if (lockCycles != `RESET_CYCLES) begin
          $display("Peripheral reset released %0d cycles after lock, expected %0d",
                   lockCycles, `RESET_CYCLES);
          numProtocolErrors++;
        end
        if (ciReset) begin
          $display("ciReset still high after the peripheral reset was released");
          numProtocolErrors++;
        end
      end else begin
        lockCycles++;
        if (!ciReset) begin
          $display("ciReset fell before the peripheral reset was released");
          numProtocolErrors++;
        end
      end
    end

    if (ciReset) begin
      if (ciDone !== 1'b0 || ciResult !== '0) begin
        $display("The DUT answered while ciReset was high");
        numProtocolErrors++;
      end
    end else begin
      if (expArm) begin
        pending       = 1'b1;
        waitCycles    = 0;
        expResultReg  = expResult;
        expLatencyReg = expLatency;
        nameReg       = testName;
      end
      if (ciDone) begin
        if (!pending) begin
          $display("Unexpected ciDone with no instruction outstanding");
          numProtocolErrors++;
        end else begin
          numChecks++;
          pending = 1'b0;
          if (ciResult !== expResultReg) begin
            $display("FAILED %0s: expected 0x%08h, actual 0x%08h",
                     nameReg, expResultReg, ciResult);
            numValueErrors++;
          end
          if (waitCycles != expLatencyReg) begin
            $display("FAILED %0s latency: expected %0d, actual %0d",
                     nameReg, expLatencyReg, waitCycles);
            numValueErrors++;
          end
        end
      end else if (pending) begin
        waitCycles++;
      end
    end
  end

endmodule

/* testbench/tbCustomInstr.sv */
`include "customInstr_consts.svh"

module tbCustomInstr
  import customInstrPkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int nameBits = 160;
  localparam int rowCapacity = 16;
  localparam int stallCount = 7;
  localparam int waitLimit = 400;
  localparam int resetLimit = 64;

  logic                s_systemClock;
  logic                s_pllLocked;
  logic                ciStart;
  ciIdT                ciN;
  ciWordT              ciDataA;
  ciWordT              ciDataB;
  logic                stall;
  logic                busIdle;
  logic                ciDone;
  ciWordT              ciResult;
  logic                ciReset;
  logic                peripheralResetN;
  logic                expArm;
  ciWordT              expResult;
  int                  expLatency;
  logic [nameBits-1:0] testName;
  int                  checkCount;
  int                  valueErrors;
  int                  protocolErrors;
  int                  timeoutCount;
  int                  seed;

  // Stimulus table
  logic [nameBits-1:0] rowName [rowCapacity];
  ciIdT                rowN [rowCapacity];
  ciWordT              rowA [rowCapacity];
  ciWordT              rowB [rowCapacity];
  int                  rowStalls [rowCapacity];
  ciWordT              rowExpect [rowCapacity];
  int                  rowTotal;

  customInstrUnit i_dut (
    .s_systemClock   (s_systemClock),
    .s_pllLocked     (s_pllLocked),
    .ciStart         (ciStart),
    .ciN             (ciN),
    .ciDataA         (ciDataA),
    .ciDataB         (ciDataB),
    .stall           (stall),
    .busIdle         (busIdle),
    .ciDone          (ciDone),
    .ciResult        (ciResult),
    .ciReset         (ciReset),
    .peripheralResetN(peripheralResetN)
  );

  ciChecker #(.nameBits(nameBits)) answerChecker (
    .s_systemClock   (s_systemClock),
    .s_pllLocked     (s_pllLocked),
    .ciReset         (ciReset),
    .peripheralResetN(peripheralResetN),
    .ciDone          (ciDone),
    .ciResult        (ciResult),
    .expArm          (expArm),
    .expResult       (expResult),
    .expLatency      (expLatency),
    .testName        (testName),
    .checkCount      (checkCount),
    .valueErrors     (valueErrors),
    .protocolErrors  (protocolErrors)
  );

  initial s_systemClock = 1'b0;
  always #20 s_systemClock = ~s_systemClock;

  // Byte i of the result takes byte 3-i, or its half-word neighbour i^1
  function automatic ciWordT swapRule(ciWordT word, logic halfWords);
    ciWordT result;
    int     src;
    for (int i = 0; i < 4; i++) begin
      src = halfWords ? (i ^ 1) : (3 - i);
      result[8*i +: 8] = word[8*src +: 8];
    end
    return result;
  endfunction

  function automatic int expectedLatency(ciIdT n, ciWordT micros);
    if (n != `DELAY_CI_ID) begin
      return 0;
    end
    if (micros == '0) begin
      return 1;
    end
    return int'(micros) * `CYCLES_PER_MICRO;
  endfunction

  task automatic addRow(input logic [nameBits-1:0] name, input ciIdT n, input ciWordT a,
                        input ciWordT b, input int stalls, input ciWordT expected);
    rowName[rowTotal]   = name;
    rowN[rowTotal]      = n;
    rowA[rowTotal]      = a;
    rowB[rowTotal]      = b;
    rowStalls[rowTotal] = stalls;
    rowExpect[rowTotal] = expected;
    rowTotal++;
  endtask

  task automatic buildTable();
    ciWordT word;
    ciWordT ctrl;
    rowTotal = 0;
    for (int i = 0; i < 4; i++) begin
      word    = $random(seed);
      ctrl    = $random(seed);
      ctrl[0] = i[0];
      addRow(i[0] ? "swapHalf" : "swapFull", `SWAP_CI_ID, word, ctrl, 0,
             swapRule(word, ctrl[0]));
    end
    addRow("delayZero", `DELAY_CI_ID, 32'd0, '0, 0, '0);
    addRow("delayOne", `DELAY_CI_ID, 32'd1, '0, 0, '0);
    addRow("delayThree", `DELAY_CI_ID, 32'd3, '0, 0, '0);
    // Counter 1 zeroed and enabled, then stall driven for a known count
    addRow("stallStart", `PROFILE_CI_ID, 32'd1, 32'h202, stallCount, '0);
    addRow("stallStop", `PROFILE_CI_ID, 32'd1, 32'h020, 0, ciWordT'(stallCount));
    addRow("stallReread", `PROFILE_CI_ID, 32'd1, '0, 0, ciWordT'(stallCount));
    addRow("idleClear", `PROFILE_CI_ID, 32'd2, 32'h400, 0, '0);
    addRow("idleRead", `PROFILE_CI_ID, 32'd2, '0, 0, '0);
    addRow("stallReenable", `PROFILE_CI_ID, 32'd1, 32'h002, 0, ciWordT'(stallCount));
    addRow("stallZero", `PROFILE_CI_ID, 32'd1, 32'h200, 0, ciWordT'(stallCount));
    addRow("stallZeroRead", `PROFILE_CI_ID, 32'd1, '0, 0, '0);
  endtask

  task automatic applyRow(input int idx);
    logic gotDone;
    int   cycles;
    @(negedge s_systemClock);
    ciStart    = 1'b1;
    ciN        = rowN[idx];
    ciDataA    = rowA[idx];
    ciDataB    = rowB[idx];
    expArm     = 1'b1;
    expResult  = rowExpect[idx];
    expLatency = expectedLatency(rowN[idx], rowA[idx]);
    testName   = rowName[idx];
    @(posedge s_systemClock);
    gotDone = ciDone;
    @(negedge s_systemClock);
    ciStart = 1'b0;
    expArm  = 1'b0;
    ciN     = '0;
    ciDataA = '0;
    ciDataB = '0;
    cycles  = 0;
    while (!gotDone && cycles < waitLimit) begin
      @(posedge s_systemClock);
      gotDone = ciDone;
      cycles++;
    end
    if (!gotDone) begin
      $display("Timeout: no ciDone for test %0s within %0d cycles", rowName[idx], waitLimit);
      timeoutCount++;
    end
    if (rowStalls[idx] > 0) begin
      @(negedge s_systemClock);
      stall = 1'b1;
      repeat (rowStalls[idx]) @(negedge s_systemClock);
      stall = 1'b0;
    end
  endtask

  task automatic finishRun();
    int missing;
    missing = rowTotal - checkCount;
    if (missing > 0) begin
      $display("Only %0d of %0d instructions were checked", checkCount, rowTotal);
    end
    $display("Checks %0d, value errors %0d, protocol errors %0d, timeouts %0d",
             checkCount, valueErrors, protocolErrors, timeoutCount);
    if (valueErrors + protocolErrors + timeoutCount == 0 && missing == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  endtask

  initial begin
    int cycles;
    seed         = 32'h83d6646c;
    timeoutCount = 0;
    s_pllLocked  = 1'b0;
    ciStart      = 1'b0;
    ciN          = '0;
    ciDataA      = '0;
    ciDataB      = '0;
    stall        = 1'b0;
    busIdle      = 1'b0;
    expArm       = 1'b0;
    expResult    = '0;
    expLatency   = 0;
    testName     = '0;
    buildTable();

    repeat (16) @(negedge s_systemClock);
    s_pllLocked = 1'b1;
    cycles = 0;
    while (!peripheralResetN && cycles < resetLimit) begin
      @(negedge s_systemClock);
      cycles++;
    end
    if (!peripheralResetN) begin
      $display("Timeout: peripheral reset not released within %0d cycles", resetLimit);
      timeoutCount++;
    end

    // Bus stays idle so an unused counter has something to miss
    busIdle = 1'b1;
    for (int i = 0; i < rowTotal; i++) begin
      applyRow(i);
    end
    repeat (4) @(negedge s_systemClock);
    finishRun();
  end

endmodule

/* verilog/customInstrPkg.sv */
package customInstrPkg;

  // Custom instruction number
  typedef logic [7:0] ciIdT;

  // Operand and result word
  typedef logic [31:0] ciWordT;

  // Profiling counter index and per-counter mask
  typedef logic [1:0] counterSelT;
  typedef logic [3:0] counterMaskT;

endpackage

/* verilog/customInstrUnit.sv */
`include "customInstr_consts.svh"

module customInstrUnit
  import customInstrPkg::*;
(
  input  logic   s_systemClock,
  input  logic   s_pllLocked,
  input  logic   ciStart,
  input  ciIdT   ciN,
  input  ciWordT ciDataA,
  input  ciWordT ciDataB,
  input  logic   stall,
  input  logic   busIdle,
  output logic   ciDone,
  output ciWordT ciResult,
  output logic   ciReset,
  output logic   peripheralResetN
);

  logic   s_swapByteDone;
  logic   s_delayCiDone;
  logic   s_counterDone;
  ciWordT s_swapByteResult;
  ciWordT s_delayResult;
  ciWordT s_counterResult;

  resetSequencer resetSeq (
    .s_systemClock   (s_systemClock),
    .s_pllLocked     (s_pllLocked),
    .ciReset         (ciReset),
    .peripheralResetN(peripheralResetN)
  );

  swapByteIse #(.ciId(`SWAP_CI_ID)) ise1 (
    .ciStart (ciStart),
    .ciN     (ciN),
    .ciDataA (ciDataA),
    .ciDataB (ciDataB),
    .ciDone  (s_swapByteDone),
    .ciResult(s_swapByteResult)
  );

  // Blocking microsecond delay
  delayIse #(.ciId(`DELAY_CI_ID)) delayMicro (
    .s_systemClock(s_systemClock),
    .ciReset      (ciReset),
    .ciStart      (ciStart),
    .ciN          (ciN),
    .ciDataA      (ciDataA),
    .ciDone       (s_delayCiDone),
    .ciResult     (s_delayResult)
  );

  profileCounters #(.ciId(`PROFILE_CI_ID)) hardwareCounters (
    .s_systemClock(s_systemClock),
    .ciReset      (ciReset),
    .ciStart      (ciStart),
    .ciN          (ciN),
    .ciDataA      (ciDataA),
    .ciDataB      (ciDataB),
    .stall        (stall),
    .busIdle      (busIdle),
    .ciDone       (s_counterDone),
    .ciResult     (s_counterResult)
  );

  // Idle units drive zero, so a plain OR merges the answers
  assign ciDone   = s_swapByteDone | s_delayCiDone | s_counterDone;
  assign ciResult = s_swapByteResult | s_delayResult | s_counterResult;

endmodule

/* verilog/customInstr_consts.svh */
`ifndef CUSTOM_INSTR_CONSTS_SVH
`define CUSTOM_INSTR_CONSTS_SVH

// Custom instruction numbers as decoded by the units
`define SWAP_CI_ID 8'd1
`define DELAY_CI_ID 8'd6
`define PROFILE_CI_ID 8'd11

// Number of hardware profiling counters
`define NR_OF_PROFILE_COUNTERS 4

// Cycles the internal reset stays active after the PLL locks
`define RESET_CYCLES 16

// System clock runs at 25 MHz (40 ns period)
`define CYCLES_PER_MICRO 25

`endif

/* verilog/delayIse.sv */
`include "customInstr_consts.svh"

module delayIse
  import customInstrPkg::*;
#(
  parameter ciIdT ciId = `DELAY_CI_ID
) (
  input  logic   s_systemClock,
  input  logic   ciReset,
  input  logic   ciStart,
  input  ciIdT   ciN,
  input  ciWordT ciDataA,
  output logic   ciDone,
  output ciWordT ciResult
);

  localparam ciWordT prescaleReload = ciWordT'(`CYCLES_PER_MICRO - 1);

  logic   s_hit;
  logic   s_busyReg;
  logic   s_tick;
  logic   s_lastMicro;
  ciWordT s_microCountReg;
  ciWordT s_prescaleReg;

  assign s_hit       = ciStart && (ciN == ciId);
  assign s_tick      = (s_prescaleReg == '0);
  assign s_lastMicro = (s_microCountReg == ciWordT'(1));

  always_ff @(posedge s_systemClock or posedge ciReset) begin
    if (ciReset) begin
      s_busyReg       <= 1'b0;
      s_microCountReg <= '0;
      s_prescaleReg   <= '0;
    end else if (s_hit && !s_busyReg) begin
      s_busyReg <= 1'b1;
      // A zero delay still takes one cycle
      if (ciDataA == '0) begin
        s_microCountReg <= ciWordT'(1);
        s_prescaleReg   <= '0;
      end else begin
        s_microCountReg <= ciDataA;
        s_prescaleReg   <= prescaleReload;
      end
    end else if (s_busyReg) begin
      if (!s_tick) begin
        s_prescaleReg <= s_prescaleReg - 1'b1;
      end else if (s_lastMicro) begin
        s_busyReg <= 1'b0;
      end else begin
        s_microCountReg <= s_microCountReg - 1'b1;
        s_prescaleReg   <= prescaleReload;
      end
    end
  end

  // Done in the last cycle of the final microsecond
  assign ciDone   = s_busyReg && s_tick && s_lastMicro;
  assign ciResult = '0;

endmodule

/* verilog/profileCounters.sv */
`include "customInstr_consts.svh"

module profileCounters
  import customInstrPkg::*;
#(
  parameter ciIdT ciId = `PROFILE_CI_ID
) (
  input  logic   s_systemClock,
  input  logic   ciReset,
  input  logic   ciStart,
  input  ciIdT   ciN,
  input  ciWordT ciDataA,
  input  ciWordT ciDataB,
  input  logic   stall,
  input  logic   busIdle,
  output logic   ciDone,
  output ciWordT ciResult
);

  localparam int nrOfCounters = `NR_OF_PROFILE_COUNTERS;

  logic        s_hit;
  logic        s_otherIssue;
  counterSelT  s_readSel;
  counterMaskT s_setMask;
  counterMaskT s_clearMask;
  counterMaskT s_zeroMask;
  counterMaskT s_events;
  counterMaskT s_enableReg;
  ciWordT      s_counterReg [nrOfCounters];

  // Issues are ignored while the internal reset is active
  assign s_hit        = ciStart && !ciReset && (ciN == ciId);
  assign s_otherIssue = ciStart && (ciN != ciId);
  assign s_readSel    = ciDataA[1:0];

  // Control fields only count for our own instruction
  assign s_setMask   = s_hit ? ciDataB[3:0] : '0;
  assign s_clearMask = s_hit ? ciDataB[7:4] : '0;
  assign s_zeroMask  = s_hit ? ciDataB[11:8] : '0;

  // Cycles, stall cycles, bus-idle cycles, foreign instruction issues
  assign s_events = {s_otherIssue, busIdle, stall, 1'b1};

  always_ff @(posedge s_systemClock or posedge ciReset) begin
    if (ciReset) begin
      s_enableReg <= '0;
    end else begin
      s_enableReg <= (s_enableReg | s_setMask) & ~s_clearMask;
    end
  end

  always_ff @(posedge s_systemClock or posedge ciReset) begin
    if (ciReset) begin
      for (int i = 0; i < nrOfCounters; i++) begin
        s_counterReg[i] <= '0;
      end
    end else begin
      for (int i = 0; i < nrOfCounters; i++) begin
        // Zeroing wins over a pending increment
        if (s_zeroMask[i]) begin
          s_counterReg[i] <= '0;
        end else if (s_enableReg[i] && s_events[i]) begin
          s_counterReg[i] <= s_counterReg[i] + 1'b1;
        end
      end
    end
  end

  // Read returns the value before this instruction takes effect
  assign ciDone   = s_hit;
  assign ciResult = s_hit ? s_counterReg[s_readSel] : '0;

endmodule

/* verilog/resetSequencer.sv */
`include "customInstr_consts.svh"

module resetSequencer (
  input  logic s_systemClock,
  input  logic s_pllLocked,
  output logic ciReset,
  output logic peripheralResetN
);

  localparam int countWidth = $clog2(`RESET_CYCLES + 1);

  logic [countWidth-1:0] s_resetCountReg;
  logic                  s_resetDone;

  assign s_resetDone = (s_resetCountReg == countWidth'(`RESET_CYCLES));

  // Saturates once the reset length is reached
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      s_resetCountReg <= '0;
    end else if (!s_resetDone) begin
      s_resetCountReg <= s_resetCountReg + 1'b1;
    end
  end

  assign ciReset          = ~s_resetDone;
  assign peripheralResetN = s_resetDone;

endmodule

/* verilog/swapByteIse.sv */
`include "customInstr_consts.svh"

module swapByteIse
  import customInstrPkg::*;
#(
  parameter ciIdT ciId = `SWAP_CI_ID
) (
  input  logic   ciStart,
  input  ciIdT   ciN,
  input  ciWordT ciDataA,
  input  ciWordT ciDataB,
  output logic   ciDone,
  output ciWordT ciResult
);

  logic   s_hit;
  ciWordT s_swapped;

  assign s_hit = ciStart && (ciN == ciId);

  always_comb begin
    if (ciDataB[0]) begin
      // Swap bytes inside each half-word
      s_swapped = {ciDataA[23:16], ciDataA[31:24], ciDataA[7:0], ciDataA[15:8]};
    end else begin
      // Full endianness reversal
      s_swapped = {ciDataA[7:0], ciDataA[15:8], ciDataA[23:16], ciDataA[31:24]};
    end
  end

  // Answered in the issue cycle
  assign ciDone   = s_hit;
  assign ciResult = s_hit ? s_swapped : '0;

endmodule

/* vlog.f */
+incdir+verilog
verilog/customInstrPkg.sv
verilog/resetSequencer.sv
verilog/swapByteIse.sv
verilog/delayIse.sv
verilog/profileCounters.sv
verilog/customInstrUnit.sv
testbench/ciChecker.sv
testbench/tbCustomInstr.sv
